/* cpu8.f */
hdl/cpu8_pkg.sv
hdl/stage_reg.sv
hdl/unified_memory.sv
hdl/control_unit.sv
hdl/register_file.sv
hdl/hazard_forward_unit.sv
hdl/execute_unit.sv
hdl/cpu8_top.sv
bench/cpu8_assertions.sv
bench/cpu8_tb.sv

/* run.sh */
#!/usr/bin/env bash
# build the cpu8 testbench with Verilator, run it and check the log

cd "$(dirname "$0")" || exit 1

build_dir=obj_dir
log_file=sim.log

verilator --binary --timing --assert \
    --top-module cpu8_tb \
    --Mdir "$build_dir" \
    -f cpu8.f
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

"./$build_dir/Vcpu8_tb" | tee "$log_file"
sim_status=${PIPESTATUS[0]}
if [ "$sim_status" -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

if grep -qx "all tests passed" "$log_file"; then
    echo "PASS"
    exit 0
else
    echo "FAIL"
    exit 1
fi

/* hdl/program.hex */
60        // 00 in r0
84 05     // 01 ldm r1 05
24        // 03 add r1 r0 sets flags
71        // 04 out r1 gives x+5
88 f0     // 05 ldm r2 f0
a6        // 07 std r1 to m[r2]
9e        // 08 ldd r3 from m[r2]
73        // 09 out r3 after load-use stall
8c 10     // 0a ldm r3 with skip address
d3        // 0c jc r3
8c aa     // 0d ldm r3 aa on fall-through
73        // 0f out r3
52        // 10 skip label or r0 r2
70        // 11 out r0
8c 19     // 12 ldm r3 with end address
30        // 14 sub r0 r0 sets z
b3        // 15 jz r3
8c 11     // 16 ldm r3 11 never reached
73        // 18 out r3
8c 55     // 19 end label ldm r3 55
73        // 1b out r3
84 1e     // 1c ldm r1 with jmp address
e1        // 1e jmp r1 spins here
00 00     // 1f pad with nops

/* bench/cpu8_tests.txt */
# name in_port count out0 out1 out2 out3 out4 with every byte in hex
# output order is x+5 then x+5 reloaded from memory then aa unless x+5 carries
# then x or f0 and finally 55
# unused output slots hold 00
in_00   00 5 05 05 AA F0 55
in_10   10 5 15 15 AA F0 55
in_7f   7F 5 84 84 AA FF 55
# largest input without a carry out of the add
in_fa   FA 5 FF FF AA FA 55
# carry set so jc skips the aa output
in_fb   FB 4 00 00 FB 55 00
in_ff   FF 4 04 04 FF 55 00

/* bench/cpu8_tb.sv */
`timescale 1ns/1ps

module cpu8_tb;
    import cpu8_pkg::*;

    localparam int    clk_period      = 100;
    localparam int    reset_cycles    = 10;
    localparam int    settle_cycles   = 30;   // quiet time for stray strobes
    localparam int    collect_limit   = 150;  // cycles allowed to gather outputs
    localparam int    cycles_per_test = 300;  // watchdog budget
    localparam int    max_outputs     = 5;    // bytes per line in the file
    localparam string tests_file      = "bench/cpu8_tests.txt";

    logic  clk;
    logic  reset;
    word_t in_port;
    word_t out_port;
    logic  out_strobe;

    string names[$];
    word_t in_vals[$];
    int    counts[$];
    word_t expected[$];  // max_outputs bytes per test

    int    got_count;
    int    test_errors;
    int    passed;
    int    failed;
    int    watchdog_cycles;
    logic  stall_seen = 1'b0;

    cpu8_top DUT (
        .clk        (clk),
        .reset      (reset),
        .in_port    (in_port),
        .out_port   (out_port),
        .out_strobe (out_strobe)
    );

    bind cpu8_top cpu8_assertions u_checks (
        .clk        (clk),
        .reset      (reset),
        .out_strobe (out_strobe),
        .out_port   (out_port),
        .stall      (stall)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #(clk_period / 2) clk = ~clk;
        end
    end

    function automatic string name_text(input logic [8*24-1:0] raw);
        string s;
        s = "";
        for (int i = 23; i >= 0; i--) begin
            if (raw[i*8 +: 8] != 8'h00) begin
                s = $sformatf("%s%c", s, raw[i*8 +: 8]);  // skip the null padding
            end
        end
        return s;
    endfunction

    task automatic load_tests();
        int               fd;
        int               n;
        logic [8*128-1:0] line;
        logic [8*24-1:0]  raw_name;
        word_t            x;
        int               cnt;
        word_t            e0;
        word_t            e1;
        word_t            e2;
        word_t            e3;
        word_t            e4;
        fd = $fopen(tests_file, "r");
        if (fd == 0) begin
            $display("could not open %s", tests_file);
        end else begin
            while (!$feof(fd)) begin
                line = '0;
                n = $fgets(line, fd);
                if (n > 0 && $sscanf(line, "%s %h %d %h %h %h %h %h", raw_name, x, cnt,
                                     e0, e1, e2, e3, e4) == 8) begin  // comment lines fall out here
                    names.push_back(name_text(raw_name));
                    in_vals.push_back(x);
                    counts.push_back(cnt);
                    expected.push_back(e0);
                    expected.push_back(e1);
                    expected.push_back(e2);
                    expected.push_back(e3);
                    expected.push_back(e4);
                end
            end
            $fclose(fd);
        end
        if (names.size() == 0) begin
            $display("no tests were read from %s", tests_file);
        end
    endtask

    // one negedge sample, outputs settled since the last posedge
    task automatic sample_outputs(input int t);
        word_t exp_byte;
        if (out_strobe) begin
            if (got_count < counts[t]) begin
                exp_byte = expected[t * max_outputs + got_count];
                if (out_port !== exp_byte) begin
                    $display("MISMATCH %s output %0d expected %02h actual %02h",
                             names[t], got_count, exp_byte, out_port);
                    test_errors++;
                end
            end else begin
                $display("%s: extra strobe after %0d outputs with out_port %02h",
                         names[t], counts[t], out_port);
                test_errors++;
            end
            got_count++;
        end else if (out_port !== 8'h00) begin
            $display("MISMATCH %s idle out_port expected 00 actual %02h", names[t], out_port);
            test_errors++;
        end
    endtask

    task automatic run_test(input int t);
        int cycles;
        got_count   = 0;
        test_errors = 0;
        cycles      = 0;
        @(posedge clk);
        reset   <= 1'b1;
        in_port <= in_vals[t];  // held for the whole program
        for (int i = 0; i < reset_cycles; i++) begin
            @(negedge clk);
            if (i > 0 && out_strobe) begin
                $display("%s: out_strobe high during reset", names[t]);
                test_errors++;
            end
        end
        @(posedge clk);
        reset <= 1'b0;
        while (got_count < counts[t] && cycles < collect_limit) begin
            @(negedge clk);
            sample_outputs(t);
            cycles++;
        end
        if (got_count < counts[t]) begin
            $display("%s: only %0d of %0d outputs arrived within %0d cycles",
                     names[t], got_count, counts[t], collect_limit);
            test_errors++;
        end
        repeat (settle_cycles) begin
            @(negedge clk);
            sample_outputs(t);  // anything here is a stray strobe
        end
        if (test_errors == 0) begin
            $display("PASS %s", names[t]);
            passed++;
        end else begin
            $display("FAIL %s with %0d errors", names[t], test_errors);
            failed++;
        end
    endtask

    // load-use should never hold the front end twice in a row
    always @(negedge clk) begin
        if (!reset && DUT.stall && stall_seen) begin
            $display("pipeline stall held for two cycles at %0t", $time);
            test_errors++;
        end
        stall_seen = DUT.stall;
    end

    initial begin
        reset           = 1'b1;
        in_port         = '0;
        passed          = 0;
        failed          = 0;
        got_count       = 0;
        test_errors     = 0;
        watchdog_cycles = 0;
        load_tests();
        watchdog_cycles = names.size() * cycles_per_test;
        for (int t = 0; t < names.size(); t++) begin
            run_test(t);
        end
        $display("%0d tests run, %0d passed, %0d failed", names.size(), passed, failed);
        if (failed == 0 && names.size() > 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

    initial begin
        wait (watchdog_cycles > 0);
        repeat (watchdog_cycles) @(posedge clk);
        $display("watchdog expired after %0d cycles", watchdog_cycles);
        $display("tests failed");
        $finish;
    end

endmodule

/* bench/cpu8_assertions.sv */
`timescale 1ns/1ps

module cpu8_assertions (
    input logic            clk,
    input logic            reset,
    input logic            out_strobe,
    input cpu8_pkg::word_t out_port,
    input logic            stall      // load-use hold from the hazard unit
);

    // MEM/WB is cleared by the first reset edge
    strobe_quiet_in_reset: assert property (
        @(posedge clk) reset && $past(reset) |-> !out_strobe
    ) else $error("out_strobe high while reset is held");

    port_zero_when_idle: assert property (
        @(posedge clk) disable iff (reset) !out_strobe |-> out_port == '0
    ) else $error("out_port nonzero without out_strobe");

    // the bubble in ID/EX removes the load on the next cycle
    stall_single_cycle: assert property (
        @(posedge clk) disable iff (reset) stall |=> !stall
    ) else $error("load-use stall lasted more than one cycle");

endmodule

/* hdl/cpu8_top.sv */
`timescale 1ns/1ps

module cpu8_top (
    input  logic            clk,
    input  logic            reset,
    input  cpu8_pkg::word_t in_port,
    output cpu8_pkg::word_t out_port,
    output logic            out_strobe
);
    import cpu8_pkg::*;

    word_t      pc;
    word_t      pc_next;
    word_t      fetch_byte;     // port A
    word_t      load_data;      // port B
    word_t      rf_a;
    word_t      rf_b;
    word_t      wb_value;
    word_t      alu_result;
    word_t      store_data;
    word_t      branch_target;
    logic       branch_taken;
    logic       stall;
    logic       flush_front;
    logic       ldm_skip;
    logic       if_id_flush;
    logic [1:0] fwd_a;
    logic [1:0] fwd_b;
    if_id_t     if_id_q;
    id_ex_t     id_ex_d;
    id_ex_t     id_ex_q;
    ex_mem_t    ex_mem_d;
    ex_mem_t    ex_mem_q;
    mem_wb_t    mem_wb_d;
    mem_wb_t    mem_wb_q;

    assign pc_next = branch_taken ? branch_target : pc + word_t'(1);

    always_ff @(posedge clk) begin
        if (reset) begin
            pc <= '0;
        end else if (!stall) begin
            pc <= pc_next;  // hold on load-use
        end
    end

    unified_memory u_mem (
        .clk     (clk),
        .addr_a  (pc),
        .data_a  (fetch_byte),
        .addr_b  (ex_mem_q.result),
        .data_b  (load_data),
        .we_b    (ex_mem_q.mem_write),
        .wdata_b (ex_mem_q.store_data)
    );

    // immediate byte becomes a nop, but not while LDM waits on a stall
    assign if_id_flush = flush_front || (ldm_skip && !stall);

    stage_reg #(.payload_t(if_id_t), .bubble(nop_instr)) u_if_id (
        .clk    (clk),
        .reset  (reset),
        .enable (!stall),
        .flush  (if_id_flush),
        .d      (fetch_byte),
        .q      (if_id_q)
    );

    register_file u_rf (
        .clk   (clk),
        .reset (reset),
        .we    (mem_wb_q.reg_write),
        .wa    (mem_wb_q.rd),
        .wd    (wb_value),
        .ra    (if_id_q[3:2]),
        .rb    (if_id_q[1:0]),
        .rd_a  (rf_a),
        .rd_b  (rf_b)
    );

    control_unit u_ctrl (
        .instr      (if_id_q),
        .fetch_byte (fetch_byte),
        .in_port    (in_port),
        .rf_a       (rf_a),
        .rf_b       (rf_b),
        .decoded    (id_ex_d),
        .ldm_skip   (ldm_skip)
    );

    hazard_forward_unit u_hfu (
        .id_instr     (if_id_q),
        .ex_stage     (id_ex_q),
        .mem_stage    (ex_mem_q),
        .wb_stage     (mem_wb_q),
        .branch_taken (branch_taken),
        .stall        (stall),
        .flush_front  (flush_front),
        .fwd_a        (fwd_a),
        .fwd_b        (fwd_b)
    );

    stage_reg #(.payload_t(id_ex_t), .bubble('0)) u_id_ex (
        .clk    (clk),
        .reset  (reset),
        .enable (1'b1),
        .flush  (flush_front || stall),  // bubble on load-use
        .d      (id_ex_d),
        .q      (id_ex_q)
    );

    execute_unit u_ex (
        .clk           (clk),
        .reset         (reset),
        .ex_stage      (id_ex_q),
        .fwd_a         (fwd_a),
        .fwd_b         (fwd_b),
        .mem_result    (ex_mem_q.result),
        .wb_result     (wb_value),
        .result        (alu_result),
        .store_data    (store_data),
        .branch_taken  (branch_taken),
        .branch_target (branch_target)
    );

    always_comb begin
        ex_mem_d.result     = alu_result;
        ex_mem_d.store_data = store_data;
        ex_mem_d.rd         = id_ex_q.rd;
        ex_mem_d.reg_write  = id_ex_q.reg_write;
        ex_mem_d.mem_read   = id_ex_q.mem_read;
        ex_mem_d.mem_write  = id_ex_q.mem_write;
        ex_mem_d.out_write  = id_ex_q.out_write;
        ex_mem_d.wb_src     = id_ex_q.wb_src;
    end

    stage_reg #(.payload_t(ex_mem_t), .bubble('0)) u_ex_mem (
        .clk    (clk),
        .reset  (reset),
        .enable (1'b1),
        .flush  (1'b0),
        .d      (ex_mem_d),
        .q      (ex_mem_q)
    );

    always_comb begin
        mem_wb_d.result    = ex_mem_q.result;
        mem_wb_d.load_data = load_data;
        mem_wb_d.wb_src    = ex_mem_q.wb_src;
        mem_wb_d.rd        = ex_mem_q.rd;
        mem_wb_d.reg_write = ex_mem_q.reg_write;
        mem_wb_d.out_write = ex_mem_q.out_write;
    end

    stage_reg #(.payload_t(mem_wb_t), .bubble('0)) u_mem_wb (
        .clk    (clk),
        .reset  (reset),
        .enable (1'b1),
        .flush  (1'b0),
        .d      (mem_wb_d),
        .q      (mem_wb_q)
    );

    // IN already rides in result
    assign wb_value = (mem_wb_q.wb_src == wb_mem) ? mem_wb_q.load_data : mem_wb_q.result;

    assign out_strobe = mem_wb_q.out_write;
    assign out_port   = mem_wb_q.out_write ? mem_wb_q.result : '0;  // zero when idle

endmodule

/* hdl/execute_unit.sv */
`timescale 1ns/1ps

module execute_unit (
    input  logic             clk,
    input  logic             reset,
    input  cpu8_pkg::id_ex_t ex_stage,
    input  logic [1:0]       fwd_a,
    input  logic [1:0]       fwd_b,
    input  cpu8_pkg::word_t  mem_result,  // EX/MEM result
    input  cpu8_pkg::word_t  wb_result,   // selected WB value
    output cpu8_pkg::word_t  result,
    output cpu8_pkg::word_t  store_data,
    output logic             branch_taken,
    output cpu8_pkg::word_t  branch_target
);
    import cpu8_pkg::*;

    word_t           a_fwd;
    word_t           b_fwd;
    word_t           op_b;
    logic [data_w:0] wide;       // msb is carry or borrow
    flags_t          flags;
    flags_t          alu_flags;

    function automatic word_t fwd_mux(input logic [1:0] sel, input word_t reg_val,
                                      input word_t mem_val, input word_t wb_val);
        case (sel)
            2'b10:   return mem_val;
            2'b01:   return wb_val;
            default: return reg_val;
        endcase
    endfunction

    assign a_fwd = fwd_mux(fwd_a, ex_stage.ra_val, mem_result, wb_result);
    assign b_fwd = fwd_mux(fwd_b, ex_stage.rb_val, mem_result, wb_result);

    always_comb begin
        if (ex_stage.use_imm) begin
            op_b = ex_stage.imm;       // LDM
        end else if (ex_stage.wb_src == wb_in) begin
            op_b = ex_stage.in_val;    // IN
        end else begin
            op_b = b_fwd;
        end
    end

    always_comb begin
        alu_flags = flags;  // c survives and/or
        case (ex_stage.alu_op)
            alu_add: wide = {1'b0, a_fwd} + {1'b0, op_b};
            alu_sub: wide = {1'b0, a_fwd} - {1'b0, op_b};
            alu_and: wide = {1'b0, a_fwd & op_b};
            alu_or:  wide = {1'b0, a_fwd | op_b};
            default: wide = {1'b0, op_b};
        endcase
        alu_flags.z = (wide[data_w-1:0] == '0);
        alu_flags.n = wide[data_w-1];
        if (ex_stage.alu_op == alu_add || ex_stage.alu_op == alu_sub) begin
            alu_flags.c = wide[data_w];
        end
    end

    assign result        = wide[data_w-1:0];
    assign store_data    = a_fwd;  // STD writes ra
    assign branch_target = b_fwd;  // jumps go to R[rb]

    always_ff @(posedge clk) begin
        if (reset) begin
            flags <= '0;
        end else if (ex_stage.update_flags) begin
            flags <= alu_flags;
        end
    end

    always_comb begin
        case (ex_stage.br_kind)
            br_z:      branch_taken = flags.z;
            br_n:      branch_taken = flags.n;
            br_c:      branch_taken = flags.c;
            br_always: branch_taken = 1'b1;
            default:   branch_taken = 1'b0;
        endcase
    end

endmodule

/* hdl/hazard_forward_unit.sv */
`timescale 1ns/1ps

module hazard_forward_unit (
    input  cpu8_pkg::word_t   id_instr,
    input  cpu8_pkg::id_ex_t  ex_stage,
    input  cpu8_pkg::ex_mem_t mem_stage,
    input  cpu8_pkg::mem_wb_t wb_stage,
    input  logic              branch_taken,
    output logic              stall,
    output logic              flush_front,
    output logic [1:0]        fwd_a,   // 00 reg, 01 MEM/WB, 10 EX/MEM
    output logic [1:0]        fwd_b
);
    import cpu8_pkg::*;

    reg_idx_t id_ra;
    reg_idx_t id_rb;
    logic     load_use;
    logic     mem_fwd_ok;

    assign id_ra = id_instr[3:2];
    assign id_rb = id_instr[1:0];

    // load in EX feeding either ID source, conservative on unused fields
    assign load_use = ex_stage.mem_read && ex_stage.reg_write &&
                      (ex_stage.rd == id_ra || ex_stage.rd == id_rb);

    assign stall       = load_use && !branch_taken;  // branch wins
    assign flush_front = branch_taken;

    // a load in EX/MEM only holds its address
    assign mem_fwd_ok = mem_stage.reg_write && !mem_stage.mem_read;

    always_comb begin
        fwd_a = 2'b00;
        if (mem_fwd_ok && mem_stage.rd == ex_stage.ra) begin
            fwd_a = 2'b10;  // youngest first
        end else if (wb_stage.reg_write && wb_stage.rd == ex_stage.ra) begin
            fwd_a = 2'b01;
        end
    end

    always_comb begin
        fwd_b = 2'b00;
        if (mem_fwd_ok && mem_stage.rd == ex_stage.rb) begin
            fwd_b = 2'b10;
        end else if (wb_stage.reg_write && wb_stage.rd == ex_stage.rb) begin
            fwd_b = 2'b01;
        end
    end

endmodule

/* hdl/register_file.sv */
`timescale 1ns/1ps

module register_file (
    input  logic               clk,
    input  logic               reset,
    input  logic               we,
    input  cpu8_pkg::reg_idx_t wa,
    input  cpu8_pkg::word_t    wd,
    input  cpu8_pkg::reg_idx_t ra,
    input  cpu8_pkg::reg_idx_t rb,
    output cpu8_pkg::word_t    rd_a,
    output cpu8_pkg::word_t    rd_b
);
    import cpu8_pkg::*;

    word_t regs [4];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < 4; i++) begin
                regs[i] <= '0;
            end
        end else if (we) begin
            regs[wa] <= wd;  // WB write
        end
    end

    // write-through covers the WB/ID overlap
    assign rd_a = (we && wa == ra) ? wd : regs[ra];
    assign rd_b = (we && wa == rb) ? wd : regs[rb];

endmodule

/* hdl/control_unit.sv */
`timescale 1ns/1ps

module control_unit (
    input  cpu8_pkg::word_t  instr,       // IF/ID byte
    input  cpu8_pkg::word_t  fetch_byte,  // port A, LDM immediate
    input  cpu8_pkg::word_t  in_port,
    input  cpu8_pkg::word_t  rf_a,
    input  cpu8_pkg::word_t  rf_b,
    output cpu8_pkg::id_ex_t decoded,
    output logic             ldm_skip
);
    import cpu8_pkg::*;

    opcode_t op;
    id_ex_t  d;

    assign op = opcode_t'(instr[7:4]);

    always_comb begin
        d        = '0;          // defaults to a bubble
        d.ra     = instr[3:2];
        d.rb     = instr[1:0];
        d.rd     = instr[3:2];  // every writer targets ra
        d.ra_val = rf_a;
        d.rb_val = rf_b;
        d.imm    = fetch_byte;
        d.in_val = in_port;
        d.alu_op = alu_pass_b;
        d.wb_src = wb_alu;
        case (op)
            op_mov: d.reg_write = 1'b1;
            op_add: begin
                d.reg_write    = 1'b1;
                d.alu_op       = alu_add;
                d.update_flags = 1'b1;
            end
            op_sub: begin
                d.reg_write    = 1'b1;
                d.alu_op       = alu_sub;
                d.update_flags = 1'b1;
            end
            op_and: begin
                d.reg_write    = 1'b1;
                d.alu_op       = alu_and;
                d.update_flags = 1'b1;  // c kept in the alu
            end
            op_or: begin
                d.reg_write    = 1'b1;
                d.alu_op       = alu_or;
                d.update_flags = 1'b1;
            end
            op_in: begin
                d.reg_write = 1'b1;
                d.wb_src    = wb_in;
            end
            op_out: d.out_write = 1'b1;  // value is R[rb] via pass_b
            op_ldm: begin
                d.reg_write = 1'b1;
                d.use_imm   = 1'b1;
            end
            op_ldd: begin
                d.reg_write = 1'b1;
                d.mem_read  = 1'b1;
                d.wb_src    = wb_mem;
            end
            op_std: d.mem_write = 1'b1;  // addr rb, data ra
            op_jz:  d.br_kind = br_z;
            op_jn:  d.br_kind = br_n;
            op_jc:  d.br_kind = br_c;
            op_jmp: d.br_kind = br_always;
            default: ;  // nop and unused codes
        endcase
    end

    assign decoded  = d;
    assign ldm_skip = (op == op_ldm);  // drop the immediate byte from IF/ID

endmodule

/* hdl/unified_memory.sv */
`timescale 1ns/1ps

module unified_memory (
    input  logic            clk,
    input  cpu8_pkg::word_t addr_a,   // fetch
    output cpu8_pkg::word_t data_a,
    input  cpu8_pkg::word_t addr_b,   // data access
    output cpu8_pkg::word_t data_b,
    input  logic            we_b,
    input  cpu8_pkg::word_t wdata_b
);
    import cpu8_pkg::*;

    word_t mem [mem_depth];  // program and data in one array

    initial begin
        $readmemh(program_file, mem);
    end

    assign data_a = mem[addr_a];  // async read
    assign data_b = mem[addr_b];

    always_ff @(posedge clk) begin
        if (we_b) begin
            mem[addr_b] <= wdata_b;  // store from MEM stage
        end
    end

endmodule

/* hdl/stage_reg.sv */
`timescale 1ns/1ps

module stage_reg #(
    parameter type      payload_t = logic [7:0],
    parameter payload_t bubble    = '0  // value loaded on reset or flush
) (
    input  logic     clk,
    input  logic     reset,
    input  logic     enable,  // low holds the stage
    input  logic     flush,
    input  payload_t d,
    output payload_t q
);

    always_ff @(posedge clk) begin
        if (reset || flush) begin
            q <= bubble;  // flush beats enable
        end else if (enable) begin
            q <= d;
        end
    end

endmodule

/* hdl/cpu8_pkg.sv */
package cpu8_pkg;

    localparam int data_w    = 8;    // machine word width
    localparam int mem_depth = 256;  // shared code and data bytes

    typedef logic [data_w-1:0] word_t;
    typedef logic [1:0]        reg_idx_t;  // r0..r3

    typedef enum logic [3:0] {
        op_nop = 4'd0,
        op_mov = 4'd1,   // ra <- rb
        op_add = 4'd2,
        op_sub = 4'd3,
        op_and = 4'd4,
        op_or  = 4'd5,
        op_in  = 4'd6,
        op_out = 4'd7,
        op_ldm = 4'd8,   // two bytes, imm follows
        op_ldd = 4'd9,
        op_std = 4'd10,
        op_jz  = 4'd11,
        op_jn  = 4'd12,
        op_jc  = 4'd13,
        op_jmp = 4'd14
    } opcode_t;

    typedef enum logic [2:0] {
        alu_pass_b = 3'd0,  // zero so a bubble is harmless
        alu_add    = 3'd1,
        alu_sub    = 3'd2,
        alu_and    = 3'd3,
        alu_or     = 3'd4
    } alu_op_t;

    typedef enum logic [2:0] {
        br_none   = 3'd0,
        br_z      = 3'd1,
        br_n      = 3'd2,
        br_c      = 3'd3,
        br_always = 3'd4
    } br_kind_t;

    typedef struct packed {
        logic z;
        logic n;
        logic c;  // carry, or borrow after sub
    } flags_t;

    typedef enum logic [1:0] {
        wb_alu = 2'd0,
        wb_mem = 2'd1,
        wb_in  = 2'd2   // in_port sample, carried through the alu
    } wb_src_t;

    localparam word_t nop_instr = 8'h00;
    localparam string program_file = "hdl/program.hex";

    typedef word_t if_id_t;  // just the fetched byte

    typedef struct packed {
        logic     reg_write;
        logic     mem_read;
        logic     mem_write;
        logic     out_write;
        wb_src_t  wb_src;
        alu_op_t  alu_op;
        logic     update_flags;
        br_kind_t br_kind;
        reg_idx_t rd;
        reg_idx_t ra;
        reg_idx_t rb;
        word_t    ra_val;
        word_t    rb_val;
        word_t    imm;     // byte after LDM
        logic     use_imm;
        word_t    in_val;  // in_port sampled in ID
    } id_ex_t;

    typedef struct packed {
        word_t    result;      // alu out, also the memory address
        word_t    store_data;
        reg_idx_t rd;
        logic     reg_write;
        logic     mem_read;
        logic     mem_write;
        logic     out_write;
        wb_src_t  wb_src;
    } ex_mem_t;

    typedef struct packed {
        word_t    result;
        word_t    load_data;
        wb_src_t  wb_src;
        reg_idx_t rd;
        logic     reg_write;
        logic     out_write;
    } mem_wb_t;

endpackage
